// ==== common/riscvPkg.sv ====
package riscvPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opI      = 7'b0010011,
        opLui    = 7'b0110111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluCtrlT;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSrcT;

    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10,
        resImm     = 2'b11
    } resultSrcT;

    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } forwardT;

    localparam logic [2:0] funct3Beq    = 3'b000;
    localparam logic [2:0] funct3Bne    = 3'b001;
    localparam logic [2:0] funct3AddSub = 3'b000;
    localparam logic [2:0] funct3Slt    = 3'b010;
    localparam logic [2:0] funct3Or     = 3'b110;
    localparam logic [2:0] funct3And    = 3'b111;

    localparam logic [31:0] resetVector = 32'h0000_0000;

    // Predictor geometry
    localparam int btbEntries = 16;
    localparam int btbIdxBits = 4;
    localparam int btbTagBits = 30 - btbIdxBits; // PC bits above the index
    localparam int ghrBits    = 4;
    localparam int phtEntries = 2 ** ghrBits;

endpackage

// ==== common/branchUpdateIf.sv ====
interface branchUpdateIf import riscvPkg::*;;

    logic               btbWe;
    logic [31:0]        btbPc;      // PC of the resolved instruction
    logic [31:0]        btbTarget;
    logic               btbIsJump;
    logic               phtWe;
    logic               phtInc;     // Branch was taken
    logic [ghrBits-1:0] phtIdx;
    logic               ghrReset;

    modport execSide (
        output btbWe, btbPc, btbTarget, btbIsJump, phtWe, phtInc, phtIdx, ghrReset
    );

    modport predSide (
        input btbWe, btbPc, btbTarget, btbIsJump, phtWe, phtInc, phtIdx, ghrReset
    );

endinterface

// ==== hdl/controller.sv ====
module controller import riscvPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  opcodeT    op_i,
    input  logic [2:0] funct3_i,
    input  logic      funct7b5_i,
    input  logic      flushE_i,
    output immSrcT    immSrcD_o,
    output logic      regWriteW_o,
    output logic      regWriteM_o,
    output resultSrcT resultSrcE_o,
    output resultSrcT resultSrcM_o,
    output resultSrcT resultSrcW_o,
    output logic      memWriteM_o,
    output aluCtrlT   aluCtrlE_o,
    output logic      aluSrcE_o,
    output logic      branchE_o,
    output logic      jumpE_o,
    output logic      jalrE_o
);

    logic      regWriteD, memWriteD, aluSrcD, branchD, jumpD, jalrD;
    resultSrcT resultSrcD;
    aluCtrlT   aluCtrlD;
    logic      regWriteE, memWriteE;

    // Main and ALU decode
    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        aluSrcD    = 1'b0;
        branchD    = 1'b0;
        jumpD      = 1'b0;
        jalrD      = 1'b0;
        resultSrcD = resAlu;
        immSrcD_o  = immI;
        aluCtrlD   = aluAdd;
        case (op_i)
            opR, opI: begin
                regWriteD = 1'b1;
                aluSrcD   = (op_i == opI);
                case (funct3_i)
                    funct3AddSub: aluCtrlD = (op_i == opR && funct7b5_i) ? aluSub : aluAdd;
                    funct3Slt:    aluCtrlD = aluSlt;
                    funct3Or:     aluCtrlD = aluOr;
                    funct3And:    aluCtrlD = aluAnd;
                    default:      aluCtrlD = aluAdd;
                endcase
            end
            opLui: begin
                regWriteD  = 1'b1;
                resultSrcD = resImm;
                immSrcD_o  = immU;
            end
            opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = resMem;
            end
            opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD_o = immS;
            end
            opBranch: begin
                branchD   = 1'b1;
                immSrcD_o = immB;
                aluCtrlD  = aluSub; // Compare via zero flag
            end
            opJal: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                resultSrcD = resPcPlus4;
                immSrcD_o  = immJ;
            end
            opJalr: begin
                regWriteD  = 1'b1;
                jalrD      = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = resPcPlus4;
            end
            default: ; // Bubble or unsupported opcode has no side effects
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            regWriteE    <= 1'b0;
            memWriteE    <= 1'b0;
            aluSrcE_o    <= 1'b0;
            branchE_o    <= 1'b0;
            jumpE_o      <= 1'b0;
            jalrE_o      <= 1'b0;
            resultSrcE_o <= resAlu;
            aluCtrlE_o   <= aluAdd;
        end else begin
            regWriteE    <= regWriteD;
            memWriteE    <= memWriteD;
            aluSrcE_o    <= aluSrcD;
            branchE_o    <= branchD;
            jumpE_o      <= jumpD;
            jalrE_o      <= jalrD;
            resultSrcE_o <= resultSrcD;
            aluCtrlE_o   <= aluCtrlD;
        end
    end

    // M and W stages
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM_o  <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM_o <= resAlu;
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= resAlu;
        end else begin
            regWriteM_o  <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSrcM_o <= resultSrcE_o;
            regWriteW_o  <= regWriteM_o;
            resultSrcW_o <= resultSrcM_o;
        end
    end

endmodule

// ==== hdl/hazardUnit.sv ====
module hazardUnit import riscvPkg::*; (
    input  logic [4:0] rs1D_i,
    input  logic [4:0] rs2D_i,
    input  logic [4:0] rs1E_i,
    input  logic [4:0] rs2E_i,
    input  logic [4:0] rdE_i,
    input  logic [4:0] rdM_i,
    input  logic [4:0] rdW_i,
    input  resultSrcT  resultSrcE_i,
    input  logic       regWriteM_i,
    input  logic       regWriteW_i,
    input  logic       mispredictE_i,
    output forwardT    forwardAE_o,
    output forwardT    forwardBE_o,
    output logic       stallF_o,
    output logic       stallD_o,
    output logic       flushD_o,
    output logic       flushE_o
);

    logic loadUse;

    // M has the younger result, so it wins over W
    always_comb begin
        forwardAE_o = fwdNone;
        if (rs1E_i != 5'd0 && rs1E_i == rdM_i && regWriteM_i) forwardAE_o = fwdMem;
        else if (rs1E_i != 5'd0 && rs1E_i == rdW_i && regWriteW_i) forwardAE_o = fwdWb;

        forwardBE_o = fwdNone;
        if (rs2E_i != 5'd0 && rs2E_i == rdM_i && regWriteM_i) forwardBE_o = fwdMem;
        else if (rs2E_i != 5'd0 && rs2E_i == rdW_i && regWriteW_i) forwardBE_o = fwdWb;
    end

    // Load in E feeding the instruction in D
    assign loadUse = (resultSrcE_i == resMem) && (rdE_i != 5'd0)
                     && (rdE_i == rs1D_i || rdE_i == rs2D_i);

    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushD_o = mispredictE_i;
    assign flushE_o = loadUse || mispredictE_i; // Bubble or squash

endmodule

// ==== datapath/datapath.sv ====
module datapath import riscvPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  immSrcT             immSrcD_i,
    input  logic               regWriteW_i,
    input  resultSrcT          resultSrcM_i,
    input  resultSrcT          resultSrcW_i,
    input  aluCtrlT            aluCtrlE_i,
    input  logic               aluSrcE_i,
    input  logic               branchE_i,
    input  logic               jumpE_i,
    input  logic               jalrE_i,
    input  logic               stallF_i,
    input  logic               stallD_i,
    input  logic               flushD_i,
    input  logic               flushE_i,
    input  forwardT            forwardAE_i,
    input  forwardT            forwardBE_i,
    input  logic               predTaken_i,
    input  logic [31:0]        predTarget_i,
    output logic [31:0]        lookupPc_o,
    input  logic [ghrBits-1:0] lookupIdx_i,
    branchUpdateIf.execSide    upd,
    output opcodeT             op_o,
    output logic [2:0]         funct3_o,
    output logic               funct7b5_o,
    output logic [4:0]         rs1D_o,
    output logic [4:0]         rs2D_o,
    output logic [4:0]         rs1E_o,
    output logic [4:0]         rs2E_o,
    output logic [4:0]         rdE_o,
    output logic [4:0]         rdM_o,
    output logic [4:0]         rdW_o,
    output logic               mispredictE_o,
    output logic [31:0]        pc_o,
    input  logic [31:0]        instr_i,
    output logic [31:0]        dataAddr_o,
    output logic [31:0]        writeData_o,
    input  logic [31:0]        readData_i
);

    logic [31:0]        pcPlus4F, pcNextF, redirectPcE;
    logic [31:0]        instrD, pcD, pcPlus4D, predTargetD, immD, rd1D, rd2D;
    logic               predTakenD;
    logic [ghrBits-1:0] phtIdxD, phtIdxE;
    logic [31:0]        regFile [32];
    logic [31:0]        rd1E, rd2E, pcE, pcPlus4E, immE, predTargetE;
    logic [2:0]         funct3E;
    logic               predTakenE;
    logic [31:0]        srcAE, srcBE, writeDataE, aluResultE, targetE;
    logic               zeroE, takenE, changesFlowE;
    logic [31:0]        pcPlus4M, immM, fwdDataM;
    logic [31:0]        aluResultW, readDataW, pcPlus4W, immW, resultW;

    // Redirect beats prediction beats sequential fetch
    assign pcPlus4F   = pc_o + 32'd4;
    assign pcNextF    = mispredictE_o ? redirectPcE : (predTaken_i ? predTarget_i : pcPlus4F);
    assign lookupPc_o = pc_o;

    always_ff @(posedge clk) begin
        if (reset) pc_o <= resetVector;
        else if (mispredictE_o || !stallF_i) pc_o <= pcNextF;
    end

    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD     <= 32'h0;
            predTakenD <= 1'b0;
        end else if (!stallD_i) begin
            instrD     <= instr_i;
            predTakenD <= predTaken_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD         <= pc_o;
            pcPlus4D    <= pcPlus4F;
            predTargetD <= predTarget_i;
            phtIdxD     <= lookupIdx_i;
        end
    end

    // Decode
    assign op_o       = opcodeT'(instrD[6:0]);
    assign funct3_o   = instrD[14:12];
    assign funct7b5_o = instrD[30];
    assign rs1D_o     = instrD[19:15];
    assign rs2D_o     = instrD[24:20];

    // Register file with W write visible to same-cycle reads
    always_ff @(posedge clk) begin
        if (regWriteW_i && rdW_o != 5'd0) regFile[rdW_o] <= resultW;
    end

    assign rd1D = (rs1D_o == 5'd0) ? 32'h0 :
                  (regWriteW_i && rdW_o == rs1D_o) ? resultW : regFile[rs1D_o];
    assign rd2D = (rs2D_o == 5'd0) ? 32'h0 :
                  (regWriteW_i && rdW_o == rs2D_o) ? resultW : regFile[rs2D_o];

    always_comb begin
        case (immSrcD_i)
            immI:    immD = {{20{instrD[31]}}, instrD[31:20]};
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'h0};
            default: immD = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            rs1E_o     <= 5'd0;
            rs2E_o     <= 5'd0;
            rdE_o      <= 5'd0;
            predTakenE <= 1'b0;
        end else begin
            rs1E_o     <= rs1D_o;
            rs2E_o     <= rs2D_o;
            rdE_o      <= instrD[11:7];
            predTakenE <= predTakenD;
        end
    end

    always_ff @(posedge clk) begin
        rd1E        <= rd1D;
        rd2E        <= rd2D;
        pcE         <= pcD;
        pcPlus4E    <= pcPlus4D;
        immE        <= immD;
        funct3E     <= funct3_o;
        predTargetE <= predTargetD;
        phtIdxE     <= phtIdxD;
    end

    // Execute
    always_comb begin
        case (forwardAE_i)
            fwdMem:  srcAE = fwdDataM;
            fwdWb:   srcAE = resultW;
            default: srcAE = rd1E;
        endcase
        case (forwardBE_i)
            fwdMem:  writeDataE = fwdDataM;
            fwdWb:   writeDataE = resultW;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcBE = aluSrcE_i ? immE : writeDataE;

    always_comb begin
        case (aluCtrlE_i)
            aluSub:  aluResultE = srcAE - srcBE;
            aluAnd:  aluResultE = srcAE & srcBE;
            aluOr:   aluResultE = srcAE | srcBE;
            aluSlt:  aluResultE = {31'h0, $signed(srcAE) < $signed(srcBE)};
            default: aluResultE = srcAE + srcBE;
        endcase
    end

    assign zeroE        = (aluResultE == 32'h0);
    assign takenE       = branchE_i && ((funct3E == funct3Bne) ? !zeroE : zeroE);
    assign changesFlowE = takenE || jumpE_i || jalrE_i;
    assign targetE      = jalrE_i ? {aluResultE[31:1], 1'b0} : pcE + immE;
    assign redirectPcE  = changesFlowE ? targetE : pcPlus4E;

    // Wrong direction, or taken to a target the BTB did not hold
    assign mispredictE_o = (branchE_i || jumpE_i || jalrE_i)
                           && ((predTakenE != changesFlowE)
                               || (changesFlowE && predTargetE != targetE));

    // Single-cycle update strobe to the predictor
    assign upd.btbWe     = changesFlowE;
    assign upd.btbPc     = pcE;
    assign upd.btbTarget = targetE;
    assign upd.btbIsJump = jumpE_i || jalrE_i;
    assign upd.phtWe     = branchE_i;
    assign upd.phtInc    = takenE;
    assign upd.phtIdx    = phtIdxE;
    assign upd.ghrReset  = branchE_i && (predTakenE != takenE);

    // Memory
    always_ff @(posedge clk) begin
        if (reset) rdM_o <= 5'd0;
        else rdM_o <= rdE_o;
    end

    always_ff @(posedge clk) begin
        dataAddr_o  <= aluResultE;
        writeData_o <= writeDataE;
        pcPlus4M    <= pcPlus4E;
        immM        <= immE;
    end

    always_comb begin
        case (resultSrcM_i)
            resPcPlus4: fwdDataM = pcPlus4M;
            resImm:     fwdDataM = immM;
            default:    fwdDataM = dataAddr_o; // Loads never forward from M
        endcase
    end

    // Writeback
    always_ff @(posedge clk) begin
        if (reset) rdW_o <= 5'd0;
        else rdW_o <= rdM_o;
    end

    always_ff @(posedge clk) begin
        aluResultW <= dataAddr_o;
        readDataW  <= readData_i;
        pcPlus4W   <= pcPlus4M;
        immW       <= immM;
    end

    always_comb begin
        case (resultSrcW_i)
            resMem:     resultW = readDataW;
            resPcPlus4: resultW = pcPlus4W;
            resImm:     resultW = immW;
            default:    resultW = aluResultW;
        endcase
    end

endmodule

// ==== predictor/branchPredictor.sv ====
module branchPredictor import riscvPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        pc_i,
    output logic               predTaken_o,
    output logic [31:0]        predTarget_o,
    output logic [ghrBits-1:0] phtIdx_o,
    branchUpdateIf.predSide    upd
);

    logic [btbTagBits-1:0] btbTag    [btbEntries];
    logic [31:0]           btbTarget [btbEntries];
    logic                  btbJump   [btbEntries];
    logic [btbEntries-1:0] btbValid;
    logic [1:0]            pht [phtEntries];
    logic [ghrBits-1:0]    ghr;

    logic [btbIdxBits-1:0] lookIdx, updIdx;
    logic                  hit;

    assign lookIdx = pc_i[btbIdxBits+1:2];
    assign updIdx  = upd.btbPc[btbIdxBits+1:2];

    // Fetch-time lookup
    assign phtIdx_o     = ghr ^ pc_i[ghrBits+1:2]; // gshare index
    assign hit          = btbValid[lookIdx] && (btbTag[lookIdx] == pc_i[31:btbIdxBits+2]);
    assign predTaken_o  = hit && (btbJump[lookIdx] || pht[phtIdx_o][1]);
    assign predTarget_o = btbTarget[lookIdx];

    always_ff @(posedge clk) begin
        if (upd.btbWe) begin
            btbTag[updIdx]    <= upd.btbPc[31:btbIdxBits+2];
            btbTarget[updIdx] <= upd.btbTarget;
            btbJump[updIdx]   <= upd.btbIsJump;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            btbValid <= '0;
            ghr      <= '0;
            for (int i = 0; i < phtEntries; i++) begin
                pht[i] <= 2'b01; // Weakly not-taken
            end
        end else begin
            if (upd.btbWe) btbValid[updIdx] <= 1'b1;
            if (upd.phtWe) begin
                if (upd.phtInc && pht[upd.phtIdx] != 2'b11) begin
                    pht[upd.phtIdx] <= pht[upd.phtIdx] + 2'b01;
                end else if (!upd.phtInc && pht[upd.phtIdx] != 2'b00) begin
                    pht[upd.phtIdx] <= pht[upd.phtIdx] - 2'b01;
                end
            end
            // Mispredict clear wins over the shift
            if (upd.ghrReset) ghr <= '0;
            else if (upd.phtWe) ghr <= {ghr[ghrBits-2:0], upd.phtInc};
        end
    end

endmodule

// ==== hdl/pipelineCore.sv ====
module pipelineCore import riscvPkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] pc_o,
    input  logic [31:0] instr_i,
    output logic [31:0] dataAddr_o,
    output logic [31:0] writeData_o,
    output logic        memWrite_o,
    input  logic [31:0] readData_i
);

    opcodeT             op;
    logic [2:0]         funct3;
    logic               funct7b5;
    immSrcT             immSrcD;
    logic               regWriteM, regWriteW, aluSrcE, branchE, jumpE, jalrE;
    resultSrcT          resultSrcE, resultSrcM, resultSrcW;
    aluCtrlT            aluCtrlE;
    logic [4:0]         rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
    forwardT            forwardAE, forwardBE;
    logic               stallF, stallD, flushD, flushE, mispredictE;
    logic               predTaken;
    logic [31:0]        predTarget, lookupPc;
    logic [ghrBits-1:0] lookupIdx;

    branchUpdateIf updBus ();

    controller i_controller (
        .clk, .reset, .op_i(op), .funct3_i(funct3), .funct7b5_i(funct7b5),
        .flushE_i(flushE), .immSrcD_o(immSrcD), .regWriteW_o(regWriteW),
        .regWriteM_o(regWriteM), .resultSrcE_o(resultSrcE), .resultSrcM_o(resultSrcM),
        .resultSrcW_o(resultSrcW), .memWriteM_o(memWrite_o), .aluCtrlE_o(aluCtrlE),
        .aluSrcE_o(aluSrcE), .branchE_o(branchE), .jumpE_o(jumpE), .jalrE_o(jalrE)
    );

    hazardUnit i_hazardUnit (
        .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW), .resultSrcE_i(resultSrcE),
        .regWriteM_i(regWriteM), .regWriteW_i(regWriteW), .mispredictE_i(mispredictE),
        .forwardAE_o(forwardAE), .forwardBE_o(forwardBE), .stallF_o(stallF),
        .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE)
    );

    datapath i_datapath (
        .clk, .reset, .immSrcD_i(immSrcD), .regWriteW_i(regWriteW),
        .resultSrcM_i(resultSrcM), .resultSrcW_i(resultSrcW), .aluCtrlE_i(aluCtrlE),
        .aluSrcE_i(aluSrcE), .branchE_i(branchE), .jumpE_i(jumpE), .jalrE_i(jalrE),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD), .flushE_i(flushE),
        .forwardAE_i(forwardAE), .forwardBE_i(forwardBE), .predTaken_i(predTaken),
        .predTarget_i(predTarget), .lookupPc_o(lookupPc), .lookupIdx_i(lookupIdx),
        .upd(updBus.execSide), .op_o(op), .funct3_o(funct3), .funct7b5_o(funct7b5),
        .rs1D_o(rs1D), .rs2D_o(rs2D), .rs1E_o(rs1E), .rs2E_o(rs2E), .rdE_o(rdE),
        .rdM_o(rdM), .rdW_o(rdW), .mispredictE_o(mispredictE), .pc_o,
        .instr_i, .dataAddr_o, .writeData_o, .readData_i
    );

    branchPredictor i_branchPredictor (
        .clk, .reset, .pc_i(lookupPc), .predTaken_o(predTaken),
        .predTarget_o(predTarget), .phtIdx_o(lookupIdx), .upd(updBus.predSide)
    );

endmodule

// ==== sim/clockGen.sv ====
module clockGen (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o; // 40 ns period
    end

    initial begin
        reset_o <= 1'b1;
        repeat (4) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== sim/coreMonitor.sv ====
module coreMonitor (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic [31:0] pc_i,
    input  logic        memWrite_i,
    input  logic [31:0] dataAddr_i,
    input  logic [31:0] writeData_i,
    input  logic [31:0] golden_i [128],
    output logic        done_o,
    output int          errors_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int storeIdx;
    int passed;
    int failed;
    bit resetChecked;

    function automatic string testName(input logic [31:0] id);
        case (id)
            32'd2:   return "alu";
            32'd3:   return "loadUse";
            32'd4:   return "branchLoop";
            32'd5:   return "jalJalr";
            default: return "unknown";
        endcase
    endfunction

    task automatic checkStore();
        int          base;
        int          expCount;
        logic [31:0] expAddr;
        logic [31:0] expData;
        string       name;
        expCount = int'(golden_i[64]);
        if (storeIdx >= expCount) begin
            $display("Unexpected store of %h to %h beyond the expected list",
                     writeData_i, dataAddr_i);
            failed++;
        end else begin
            base    = 66 + 3 * storeIdx;
            expAddr = golden_i[base];
            expData = golden_i[base + 1];
            name    = testName(golden_i[base + 2]);
            if (dataAddr_i !== expAddr) begin
                $display("Mismatch %s store %0d address expected %h actual %h",
                         name, storeIdx, expAddr, dataAddr_i);
                failed++;
            end else if (writeData_i !== expData) begin
                $display("Mismatch %s store %0d expected %h actual %h",
                         name, storeIdx, expData, writeData_i);
                failed++;
            end else begin
                $display("Test %s store %0d ok, %h at %h",
                         name, storeIdx, writeData_i, dataAddr_i);
                passed++;
            end
            storeIdx++;
        end
        // Completion marker ends the program
        if (dataAddr_i == 32'h0000_00FC) begin
            if (storeIdx != expCount) begin
                $display("Completion store came after %0d of %0d expected stores",
                         storeIdx, expCount);
                failed++;
            end
            $display("Summary: %0d passed, %0d failed", passed, failed);
            errors_o = failed;
            done_o   = 1'b1;
        end
    endtask

    initial begin
        done_o       = 1'b0;
        errors_o     = 0;
        storeIdx     = 0;
        passed       = 0;
        failed       = 0;
        resetChecked = 1'b0;
    end

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk_i) begin
        if (!reset_i && !done_o) begin
            if (!resetChecked) begin
                resetChecked = 1'b1;
                if (pc_i !== 32'h0) begin
                    $display("Mismatch reset pc expected %h actual %h", 32'h0, pc_i);
                    failed++;
                end else if (memWrite_i !== 1'b0) begin
                    $display("Mismatch reset memWrite expected 0 actual %b", memWrite_i);
                    failed++;
                end else begin
                    $display("Test reset ok");
                    passed++;
                end
            end else if (memWrite_i === 1'b1) begin
                checkStore();
            end else if (memWrite_i !== 1'b0) begin
                $display("Memory write enable is unknown at pc %h", pc_i);
                failed++;
            end
        end
    end

endmodule

// ==== sim/coreChecker_checker.sv ====
module coreChecker (
    input logic        clk_i,
    input logic        reset_i,
    input logic [31:0] pc_i,
    input logic        memWrite_i,
    input logic        stallF_i,
    input logic        mispredictE_i
);
    timeunit 1ns;
    timeprecision 100ps;

    pcAligned: assert property (@(posedge clk_i) disable iff (reset_i) pc_i[1:0] == 2'b00)
        else $error("pc_o is not word aligned");

    memWriteKnown: assert property (@(posedge clk_i) disable iff (reset_i)
        !$isunknown(memWrite_i))
        else $error("memWrite_o is unknown");

    // A redirect may move the PC even while fetch stalls
    pcHeldOnStall: assert property (@(posedge clk_i) disable iff (reset_i)
        stallF_i && !mispredictE_i |=> $stable(pc_i))
        else $error("pc_o changed during a fetch stall");

endmodule

bind pipelineCore coreChecker i_coreChecker (
    .clk_i(clk),
    .reset_i(reset),
    .pc_i(pc_o),
    .memWrite_i(memWrite_o),
    .stallF_i(stallF),
    .mispredictE_i(mispredictE)
);

// ==== sim/coreTb.sv ====
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk, reset;
    logic [31:0] pc, instr, dataAddr, writeData, readData;
    logic        memWrite;
    logic [31:0] golden   [128];
    logic [31:0] instrRom [64];
    logic [31:0] dataRam  [64];
    logic        done;
    int          errors;
    int          budget;

    clockGen i_clockGen (.clk_o(clk), .reset_o(reset));

    pipelineCore i_pipelineCore (
        .clk(clk), .reset(reset), .pc_o(pc), .instr_i(instr),
        .dataAddr_o(dataAddr), .writeData_o(writeData),
        .memWrite_o(memWrite), .readData_i(readData)
    );

    coreMonitor i_coreMonitor (
        .clk_i(clk), .reset_i(reset), .pc_i(pc), .memWrite_i(memWrite),
        .dataAddr_i(dataAddr), .writeData_i(writeData), .golden_i(golden),
        .done_o(done), .errors_o(errors)
    );

    initial begin
        for (int i = 0; i < 128; i++) begin
            golden[i] = 32'h0;
        end
        $readmemh("sim/program_golden.txt", golden);
        for (int i = 0; i < 64; i++) begin
            instrRom[i] = golden[i];
            dataRam[i] <= 32'hDA7A_0000 | 32'(i * 4); // Address tagged fill
        end
    end

    // Zero-latency memories
    assign instr    = instrRom[pc[7:2]];
    assign readData = dataRam[dataAddr[7:2]];

    always @(posedge clk) begin
        if (memWrite) dataRam[dataAddr[7:2]] <= writeData;
    end

    initial begin : watchdog
        @(negedge reset);
        budget = int'(golden[65]);
        repeat (budget) @(posedge clk);
        if (!done) begin
            $display("Timeout: no completion store within %0d cycles", budget);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin : summary
        wait (done === 1'b1);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/program_golden.txt ====
// Words 00-3F: instruction ROM, four words per line from byte address 00
// Word 40: expected store count, word 41: cycle budget, then address data test triples
@00
00500093 00300113 002081B3 40118233 // addi addi add sub
0021F2B3 0021E333 001223B3 12345437 // and or slt lui
00302023 00402223 00502423 00602623 // sw x3..x6
00702823 00802A23 00002583 00258633 // sw x7 sw x8 lw add
00C02C23 00000693 00000713 00800793 // sw x12 loop setup
00168693 00D70733 FEF69CE3 00E70463 // loop body bne, beq skip
00002E23 00D02E23 02E02023 00C0086F // skipped sw, sw count sum, jal x16
0100006F 02002823 03002423 00080067 // jal x0, skipped sw, sw link, jalr
00100913 0F202E23                   // addi, completion store
@40
0000000B 00000190
// Address Data Test (2 alu, 3 loadUse, 4 branchLoop, 5 jalJalr)
00000000 00000008 00000002
00000004 00000003 00000002
00000008 00000000 00000002
0000000C 0000000B 00000002
00000010 00000001 00000002
00000014 12345000 00000002
00000018 0000000B 00000003
0000001C 00000008 00000004
00000020 00000024 00000004
00000028 00000070 00000005
000000FC 00000001 00000005

// ==== verilog.f ====
common/riscvPkg.sv
common/branchUpdateIf.sv
hdl/controller.sv
hdl/hazardUnit.sv
datapath/datapath.sv
predictor/branchPredictor.sv
hdl/pipelineCore.sv
sim/clockGen.sv
sim/coreMonitor.sv
sim/coreChecker_checker.sv
sim/coreTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module coreTb -Mdir obj_dir -f verilog.f || exit 1
./obj_dir/VcoreTb > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || grep -q "STATUS: PASS" sim.log || exit 1
exit 0
